//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // addresses
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t CSR_ADDR_MVENDORID = 12'hF11;  // machine info, read-only
  localparam csr_addr_t CSR_ADDR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_ADDR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_ADDR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_ADDR_MSTATUS   = 12'h300;  // trap setup
  localparam csr_addr_t CSR_ADDR_MISA      = 12'h301;
  localparam csr_addr_t CSR_ADDR_MIE       = 12'h304;
  localparam csr_addr_t CSR_ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_ADDR_MSCRATCH  = 12'h340;  // trap handling
  localparam csr_addr_t CSR_ADDR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_ADDR_MIP       = 12'h344;

  // fixed id words
  localparam logic [31:0] CSR_VAL_MVENDORID = 32'h0000_0000;  // non-commercial
  localparam logic [31:0] CSR_VAL_MARCHID   = 32'h0000_0000;
  localparam logic [31:0] CSR_VAL_MIMPID    = 32'h0000_0001;
  localparam logic [31:0] CSR_VAL_MISA      = 32'h4000_0100;  // mxl=1, I only

  // field positions
  localparam int CSR_BIT_MIE  = 3;   // mstatus
  localparam int CSR_BIT_MPIE = 7;
  localparam int CSR_BIT_MSI  = 3;   // mie / mip
  localparam int CSR_BIT_MTI  = 7;
  localparam int CSR_BIT_MEI  = 11;

  ////////////////////////////////////////////////////////////////////////////
  // access and state types
  ////////////////////////////////////////////////////////////////////////////
  // encoding follows funct3[1:0] of csrrw/csrrs/csrrc
  typedef enum logic [1:0] {
    WRITE = 2'd1,
    SET   = 2'd2,
    CLEAR = 2'd3
  } csr_op_e;

  typedef struct packed {
    logic        valid;
    csr_addr_t   addr;
    csr_op_e     op;
    logic [31:0] src;
    logic        src_is_zero;  // rs1/uimm is x0
  } csr_req_t;

  typedef struct packed {
    logic        we;
    csr_addr_t   addr;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;  // 0 direct, 1 vectored
  } mtvec_t;

  typedef struct packed {
    logic        mstatus_mie;
    logic        mstatus_mpie;
    logic [2:0]  mie;  // indexed by IRQ_IDX_*
    logic [2:0]  mip;
    mtvec_t      mtvec;
    logic [31:0] mepc;
  } csr_state_t;

endpackage

`default_nettype wire

//--- src/trap_pkg.sv
`default_nettype none

package trap_pkg;

  localparam int NUM_IRQ = 3;

  // slot of each line in the packed mie/mip fields
  localparam int IRQ_IDX_MSI = 0;
  localparam int IRQ_IDX_MTI = 1;
  localparam int IRQ_IDX_MEI = 2;

  localparam logic [4:0] CAUSE_MSI = 5'd3;
  localparam logic [4:0] CAUSE_MTI = 5'd7;
  localparam logic [4:0] CAUSE_MEI = 5'd11;

  // cause per slot, and slot order with entry 0 the highest priority
  localparam logic [NUM_IRQ-1:0][4:0] IRQ_CAUSE = {CAUSE_MEI, CAUSE_MTI, CAUSE_MSI};
  localparam logic [NUM_IRQ-1:0][1:0] IRQ_PRIO  =
    {2'(IRQ_IDX_MTI), 2'(IRQ_IDX_MSI), 2'(IRQ_IDX_MEI)};

  typedef struct packed {
    logic        take_trap;  // one-cycle pulses
    logic        mret;
    logic [31:0] mepc;
    logic [31:0] mcause;
  } trap_upd_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

//--- src/csr_op_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit import csr_pkg::*; (
  input  logic        clk_i,
  input  logic        rstn_i,

  input  csr_req_t    csr_req_i,     // from decode

  // combinational read of the regfile
  output csr_addr_t   rd_addr_o,
  input  logic [31:0] rd_data_i,
  input  logic        rd_known_i,
  input  logic        rd_readonly_i,

  output csr_wr_t     csr_wr_o,

  output logic [31:0] rdata_o,       // old value, one cycle later
  output logic        illegal_o
);

  logic [31:0] wdata;
  logic        does_write;  // op actually modifies the csr
  logic        illegal;
  logic        wr_en;
  logic [31:0] rdata_q;
  logic        illegal_q;

  assign rd_addr_o = csr_req_i.addr;

  // read-modify-write data
  always_comb begin
    unique case (csr_req_i.op)
      WRITE:   wdata = csr_req_i.src;
      SET:     wdata = rd_data_i | csr_req_i.src;
      CLEAR:   wdata = rd_data_i & ~csr_req_i.src;
      default: wdata = csr_req_i.src;  // 2'b00 never decoded
    endcase
  end

  // csrrs/csrrc with x0 source is a pure read
  assign does_write = (csr_req_i.op == WRITE) | ~csr_req_i.src_is_zero;

  assign illegal = csr_req_i.valid & (~rd_known_i | (rd_readonly_i & does_write));
  assign wr_en   = csr_req_i.valid & rd_known_i & ~rd_readonly_i & does_write;

  assign csr_wr_o = '{we: wr_en, addr: csr_req_i.addr, data: wdata};

  ////////////////////////////////////////////////////////////////////////////
  // read response
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rdata_q   <= '0;
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= illegal;          // single-cycle flag
      if (csr_req_i.valid) begin
        rdata_q <= rd_data_i;        // value before this access
      end
    end
  end

  assign rdata_o   = rdata_q;
  assign illegal_o = illegal_q;

endmodule

`default_nettype wire

//--- src/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile import csr_pkg::*; import trap_pkg::*; #(
  parameter logic [31:0] HART_ID     = 32'h0,
  parameter logic [31:0] MTVEC_RESET = 32'h0
) (
  input  logic        clk_i,
  input  logic        rstn_i,

  // read port
  input  csr_addr_t   rd_addr_i,
  output logic [31:0] rd_data_o,
  output logic        rd_known_o,     // address implemented
  output logic        rd_readonly_o,

  input  csr_wr_t     csr_wr_i,
  input  trap_upd_t   trap_upd_i,

  // interrupt lines, level
  input  logic        sw_irq_i,
  input  logic        timer_irq_i,
  input  logic        ext_irq_i,

  output csr_state_t  state_o
);

  logic              mstatus_mie_q;   // global enable
  logic              mstatus_mpie_q;  // enable before trap
  logic [NUM_IRQ-1:0] mie_q;
  logic [NUM_IRQ-1:0] mip_q;          // registered irq lines
  mtvec_t            mtvec_q;
  logic [31:0]       mscratch_q;
  logic [31:0]       mepc_q;
  logic [31:0]       mcause_q;

  // place a packed irq field at its architectural bit positions
  function automatic logic [31:0] irq_word(input logic [NUM_IRQ-1:0] f);
    logic [31:0] w;
    w = '0;
    w[CSR_BIT_MSI] = f[IRQ_IDX_MSI];
    w[CSR_BIT_MTI] = f[IRQ_IDX_MTI];
    w[CSR_BIT_MEI] = f[IRQ_IDX_MEI];
    return w;
  endfunction

  function automatic logic [NUM_IRQ-1:0] irq_field(input logic [31:0] w);
    logic [NUM_IRQ-1:0] f;
    f[IRQ_IDX_MSI] = w[CSR_BIT_MSI];
    f[IRQ_IDX_MTI] = w[CSR_BIT_MTI];
    f[IRQ_IDX_MEI] = w[CSR_BIT_MEI];
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_data_o     = '0;
    rd_known_o    = 1'b1;
    rd_readonly_o = 1'b0;
    case (rd_addr_i)
      CSR_ADDR_MVENDORID: begin
        rd_data_o     = CSR_VAL_MVENDORID;
        rd_readonly_o = 1'b1;
      end
      CSR_ADDR_MARCHID: begin
        rd_data_o     = CSR_VAL_MARCHID;
        rd_readonly_o = 1'b1;
      end
      CSR_ADDR_MIMPID: begin
        rd_data_o     = CSR_VAL_MIMPID;
        rd_readonly_o = 1'b1;
      end
      CSR_ADDR_MHARTID: begin
        rd_data_o     = HART_ID;
        rd_readonly_o = 1'b1;
      end
      CSR_ADDR_MISA: begin
        rd_data_o     = CSR_VAL_MISA;  // no writable extensions
        rd_readonly_o = 1'b1;
      end
      CSR_ADDR_MSTATUS: begin
        rd_data_o[CSR_BIT_MIE]  = mstatus_mie_q;
        rd_data_o[CSR_BIT_MPIE] = mstatus_mpie_q;
      end
      CSR_ADDR_MIE:      rd_data_o = irq_word(mie_q);
      CSR_ADDR_MIP:      rd_data_o = irq_word(mip_q);  // writable address, writes dropped
      CSR_ADDR_MTVEC:    rd_data_o = mtvec_q;
      CSR_ADDR_MSCRATCH: rd_data_o = mscratch_q;
      CSR_ADDR_MEPC:     rd_data_o = mepc_q;
      CSR_ADDR_MCAUSE:   rd_data_o = mcause_q;
      default:           rd_known_o = 1'b0;  // unimplemented
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state update
  ////////////////////////////////////////////////////////////////////////////
  // trap/mret assignments come last so they win over a csr write
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mip_q          <= '0;
      mtvec_q        <= mtvec_t'(MTVEC_RESET);
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
    end else begin
      mip_q[IRQ_IDX_MSI] <= sw_irq_i;
      mip_q[IRQ_IDX_MTI] <= timer_irq_i;
      mip_q[IRQ_IDX_MEI] <= ext_irq_i;

      if (csr_wr_i.we) begin
        case (csr_wr_i.addr)
          CSR_ADDR_MSTATUS: begin
            mstatus_mie_q  <= csr_wr_i.data[CSR_BIT_MIE];
            mstatus_mpie_q <= csr_wr_i.data[CSR_BIT_MPIE];
          end
          CSR_ADDR_MIE: mie_q <= irq_field(csr_wr_i.data);
          CSR_ADDR_MTVEC: begin
            mtvec_q.base <= csr_wr_i.data[31:2];
            mtvec_q.mode <= (csr_wr_i.data[1:0] == 2'd1) ? 2'd1 : 2'd0;  // reserved -> direct
          end
          CSR_ADDR_MSCRATCH: mscratch_q <= csr_wr_i.data;
          CSR_ADDR_MEPC:     mepc_q     <= {csr_wr_i.data[31:2], 2'b00};  // ialign 32
          CSR_ADDR_MCAUSE:   mcause_q   <= csr_wr_i.data;
          default: ;  // read-only and mip
        endcase
      end

      if (trap_upd_i.take_trap) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;       // handler starts masked
        mepc_q         <= trap_upd_i.mepc;
        mcause_q       <= trap_upd_i.mcause;
      end else if (trap_upd_i.mret) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end
    end
  end

  assign state_o = '{
    mstatus_mie:  mstatus_mie_q,
    mstatus_mpie: mstatus_mpie_q,
    mie:          mie_q,
    mip:          mip_q,
    mtvec:        mtvec_q,
    mepc:         mepc_q
  };

endmodule

`default_nettype wire

//--- src/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import csr_pkg::*; import trap_pkg::*; (
  input  logic        clk_i,
  input  logic        rstn_i,

  input  csr_state_t  state_i,
  input  logic        retire_i,    // instruction retired, interrupt window
  input  logic        mret_i,
  input  logic [31:0] pc_next_i,   // resume pc saved in mepc

  output trap_upd_t   trap_upd_o,
  output redirect_t   redirect_o
);

  logic [NUM_IRQ-1:0] pend_en;
  logic               irq_take;
  logic [1:0]         irq_sel;   // winning slot
  logic [4:0]         cause;
  logic [31:0]        mcause;
  logic [31:0]        trap_pc;
  logic               take_trap;
  logic               redir_vld_q;
  logic [31:0]        redir_pc_q;

  assign pend_en  = state_i.mip & state_i.mie;
  assign irq_take = state_i.mstatus_mie & (|pend_en);

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////
  // walk from lowest to highest priority, last hit wins
  always_comb begin
    irq_sel = IRQ_PRIO[0];
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (pend_en[IRQ_PRIO[i]]) begin
        irq_sel = IRQ_PRIO[i];
      end
    end
  end

  assign cause  = IRQ_CAUSE[irq_sel];
  assign mcause = {1'b1, 26'b0, cause};  // interrupt bit set

  // direct: base, vectored: base + 4*cause
  always_comb begin
    trap_pc = {state_i.mtvec.base, 2'b00};
    if (state_i.mtvec.mode == 2'd1) begin
      trap_pc = trap_pc + {25'b0, cause, 2'b00};
    end
  end

  assign take_trap = retire_i & irq_take & ~mret_i;  // mret wins

  assign trap_upd_o = '{
    take_trap: take_trap,
    mret:      mret_i,
    mepc:      pc_next_i,
    mcause:    mcause
  };

  ////////////////////////////////////////////////////////////////////////////
  // redirect, one cycle after the strobe
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      redir_vld_q <= 1'b0;
    end else begin
      redir_vld_q <= take_trap | mret_i;
    end
  end

  always_ff @(posedge clk_i) begin
    redir_pc_q <= mret_i ? state_i.mepc : trap_pc;  // mepc before any update
  end

  assign redirect_o = '{valid: redir_vld_q, pc: redir_pc_q};

endmodule

`default_nettype wire

//--- src/csr_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_subsys_top import csr_pkg::*; import trap_pkg::*; #(
  parameter logic [31:0] HART_ID     = 32'h0,
  parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic        clk_i,
  input  logic        rstn_i,

  // csr access from decode
  input  csr_req_t    csr_req_i,
  output logic [31:0] rdata_o,
  output logic        illegal_o,

  input  logic        sw_irq_i,
  input  logic        timer_irq_i,
  input  logic        ext_irq_i,

  // retire side
  input  logic        retire_i,
  input  logic        mret_i,
  input  logic [31:0] pc_next_i,
  output redirect_t   redirect_o
);

  csr_addr_t   rd_addr;
  logic [31:0] rd_data;
  logic        rd_known;
  logic        rd_readonly;
  csr_wr_t     csr_wr;
  csr_state_t  csr_state;
  trap_upd_t   trap_upd;

  csr_op_unit u_op_unit (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .csr_req_i     (csr_req_i),
    .rd_addr_o     (rd_addr),
    .rd_data_i     (rd_data),
    .rd_known_i    (rd_known),
    .rd_readonly_i (rd_readonly),
    .csr_wr_o      (csr_wr),
    .rdata_o       (rdata_o),
    .illegal_o     (illegal_o)
  );

  csr_regfile #(
    .HART_ID     (HART_ID),
    .MTVEC_RESET (MTVEC_RESET)
  ) u_regfile (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .rd_known_o    (rd_known),
    .rd_readonly_o (rd_readonly),
    .csr_wr_i      (csr_wr),
    .trap_upd_i    (trap_upd),
    .sw_irq_i      (sw_irq_i),
    .timer_irq_i   (timer_irq_i),
    .ext_irq_i     (ext_irq_i),
    .state_o       (csr_state)
  );

  trap_ctrl u_trap (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .state_i    (csr_state),
    .retire_i   (retire_i),
    .mret_i     (mret_i),
    .pc_next_i  (pc_next_i),
    .trap_upd_o (trap_upd),
    .redirect_o (redirect_o)
  );

endmodule

`default_nettype wire

//--- verif/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// shadow registers, stored at architectural bit positions
////////////////////////////////////////////////////////////////////////////
localparam logic [31:0] MSTATUS_MASK = (32'h1 << CSR_BIT_MIE) | (32'h1 << CSR_BIT_MPIE);
localparam logic [31:0] IRQ_MASK     =
  (32'h1 << CSR_BIT_MSI) | (32'h1 << CSR_BIT_MTI) | (32'h1 << CSR_BIT_MEI);

logic [31:0] sh_mstatus;
logic [31:0] sh_mie;
logic [31:0] sh_mip;
logic [31:0] sh_mtvec;    // raw word, mode in [1:0]
logic [31:0] sh_mscratch;
logic [31:0] sh_mepc;
logic [31:0] sh_mcause;

task automatic reset_shadow();
  sh_mstatus  = '0;
  sh_mie      = '0;
  sh_mip      = '0;
  sh_mtvec    = MTVEC_RESET;
  sh_mscratch = '0;
  sh_mepc     = '0;
  sh_mcause   = '0;
endtask

function automatic logic csr_is_readonly(input csr_addr_t addr);
  return addr == CSR_ADDR_MVENDORID || addr == CSR_ADDR_MARCHID || addr == CSR_ADDR_MIMPID ||
         addr == CSR_ADDR_MHARTID || addr == CSR_ADDR_MISA;
endfunction

function automatic logic csr_exists(input csr_addr_t addr);
  return csr_is_readonly(addr) || addr == CSR_ADDR_MSTATUS || addr == CSR_ADDR_MIE ||
         addr == CSR_ADDR_MTVEC || addr == CSR_ADDR_MSCRATCH || addr == CSR_ADDR_MEPC ||
         addr == CSR_ADDR_MCAUSE || addr == CSR_ADDR_MIP;
endfunction

function automatic logic [31:0] shadow_read(input csr_addr_t addr);
  case (addr)
    CSR_ADDR_MVENDORID: return CSR_VAL_MVENDORID;
    CSR_ADDR_MARCHID:   return CSR_VAL_MARCHID;
    CSR_ADDR_MIMPID:    return CSR_VAL_MIMPID;
    CSR_ADDR_MHARTID:   return HART_ID;
    CSR_ADDR_MISA:      return CSR_VAL_MISA;
    CSR_ADDR_MSTATUS:   return sh_mstatus;
    CSR_ADDR_MIE:       return sh_mie;
    CSR_ADDR_MIP:       return sh_mip;
    CSR_ADDR_MTVEC:     return sh_mtvec;
    CSR_ADDR_MSCRATCH:  return sh_mscratch;
    CSR_ADDR_MEPC:      return sh_mepc;
    CSR_ADDR_MCAUSE:    return sh_mcause;
    default:            return 32'h0;  // unknown reads as zero
  endcase
endfunction

// warl masks, mip and read-only words ignore writes
task automatic shadow_write(input csr_addr_t addr, input logic [31:0] data);
  case (addr)
    CSR_ADDR_MSTATUS:  sh_mstatus  = data & MSTATUS_MASK;
    CSR_ADDR_MIE:      sh_mie      = data & IRQ_MASK;
    CSR_ADDR_MTVEC:    sh_mtvec    = {data[31:2], (data[1:0] == 2'b01) ? 2'b01 : 2'b00};
    CSR_ADDR_MSCRATCH: sh_mscratch = data;
    CSR_ADDR_MEPC:     sh_mepc     = data & 32'hffff_fffc;
    CSR_ADDR_MCAUSE:   sh_mcause   = data;
    default: ;
  endcase
endtask

////////////////////////////////////////////////////////////////////////////
// trap rules
////////////////////////////////////////////////////////////////////////////
function automatic logic irq_taken();
  return sh_mstatus[CSR_BIT_MIE] && ((sh_mip & sh_mie) != 32'h0);
endfunction

// mei beats msi beats mti
function automatic logic [31:0] winning_cause();
  logic [31:0] pend;
  logic [31:0] cause;
  pend = sh_mip & sh_mie;
  if (pend[CSR_BIT_MEI]) cause = {27'b0, CAUSE_MEI};
  else if (pend[CSR_BIT_MSI]) cause = {27'b0, CAUSE_MSI};
  else cause = {27'b0, CAUSE_MTI};
  return cause;
endfunction

function automatic logic [31:0] trap_target(input logic [31:0] cause);
  logic [31:0] base;
  base = {sh_mtvec[31:2], 2'b00};
  if (sh_mtvec[1:0] == 2'b01) base = base + (cause << 2);  // vectored
  return base;
endfunction

task automatic enter_trap(input logic [31:0] pc, input logic [31:0] cause);
  sh_mepc                  = pc;
  sh_mcause                = 32'h8000_0000 | cause;
  sh_mstatus[CSR_BIT_MPIE] = sh_mstatus[CSR_BIT_MIE];
  sh_mstatus[CSR_BIT_MIE]  = 1'b0;
endtask

task automatic leave_trap();
  sh_mstatus[CSR_BIT_MIE]  = sh_mstatus[CSR_BIT_MPIE];
  sh_mstatus[CSR_BIT_MPIE] = 1'b1;
endtask

`endif

//--- verif/csr_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_subsys_tb import csr_pkg::*; import trap_pkg::*; ();

  localparam logic [31:0] HART_ID     = 32'h0000_0005;
  localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
  localparam int RESET_CYCLES = 5;
  localparam int N_UNK  = 8;
  localparam int N_RAND = 200;
  localparam int N_IRQ  = 50;
  localparam int N_TRAP = 60;
  localparam int N_MRET = 30;
  // per-iteration cycle costs of each test
  localparam int TEST_CYCLES = RESET_CYCLES + 1 + 3 * 5 + N_UNK + N_RAND + 3 * N_IRQ +
                               9 * N_TRAP + 10 * N_MRET;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
  localparam csr_addr_t RO_ADDRS [5] = '{CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID,
                                         CSR_ADDR_MIMPID, CSR_ADDR_MISA, CSR_ADDR_MHARTID};
  localparam csr_addr_t RW_ADDRS [6] = '{CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE,
                                         CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MTVEC};

  logic        clk_i;
  logic        rstn_i;
  csr_req_t    csr_req_i;
  logic [31:0] rdata_o;
  logic        illegal_o;
  logic        sw_irq_i;
  logic        timer_irq_i;
  logic        ext_irq_i;
  logic        retire_i;
  logic        mret_i;
  logic [31:0] pc_next_i;
  redirect_t   redirect_o;
  integer      seed;
  int          cycle_cnt;

  `include "csr_model.svh"

  csr_subsys_top #(
    .HART_ID     (HART_ID),
    .MTVEC_RESET (MTVEC_RESET)
  ) u_dut (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .csr_req_i   (csr_req_i),
    .rdata_o     (rdata_o),
    .illegal_o   (illegal_o),
    .sw_irq_i    (sw_irq_i),
    .timer_irq_i (timer_irq_i),
    .ext_irq_i   (ext_irq_i),
    .retire_i    (retire_i),
    .mret_i      (mret_i),
    .pc_next_i   (pc_next_i),
    .redirect_o  (redirect_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;  // 100 ns period
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic csr_op_e rand_op();
    logic [31:0] r;
    csr_op_e     op;
    r = rand_word();
    if (r % 32'd3 == 32'd0) op = WRITE;
    else if (r % 32'd3 == 32'd1) op = SET;
    else op = CLEAR;
    return op;
  endfunction

  function automatic logic [31:0] line_word();
    logic [31:0] w;
    w = '0;
    w[CSR_BIT_MSI] = sw_irq_i;
    w[CSR_BIT_MTI] = timer_irq_i;
    w[CSR_BIT_MEI] = ext_irq_i;
    return w;
  endfunction

  task automatic drive_lines(input logic [2:0] bits);
    sw_irq_i    = bits[0];
    timer_irq_i = bits[1];
    ext_irq_i   = bits[2];
  endtask

  // one clock, lines sampled into mip at the edge
  task automatic tick();
    logic [31:0] lines;
    lines = line_word();
    @(posedge clk_i);
    #10;
    sh_mip = lines;
  endtask

  task automatic access(input csr_addr_t addr, input csr_op_e op, input logic [31:0] src,
                        input logic zero);
    logic [31:0] old_v;
    logic [31:0] new_v;
    logic        wr;
    logic        exp_ill;
    old_v   = shadow_read(addr);
    wr      = (op == WRITE) || !zero;  // set/clear with x0 only reads
    exp_ill = !csr_exists(addr) || (csr_is_readonly(addr) && wr);
    if (op == WRITE) new_v = src;
    else if (op == SET) new_v = old_v | src;
    else new_v = old_v & ~src;
    csr_req_i = '{valid: 1'b1, addr: addr, op: op, src: src, src_is_zero: zero};
    tick();
    csr_req_i.valid = 1'b0;
    check_val("rdata_o", rdata_o, old_v);
    check_val("illegal_o", {31'b0, illegal_o}, {31'b0, exp_ill});
    if (wr && !exp_ill) shadow_write(addr, new_v);
  endtask

  // retire and/or mret pulse, redirect expected one cycle later
  task automatic retire_step(input logic ret, input logic mr, input logic [31:0] pc);
    logic        exp_trap;
    logic [31:0] cause;
    logic [31:0] exp_pc;
    exp_trap = ret && !mr && irq_taken();  // mret wins
    cause    = winning_cause();
    exp_pc   = mr ? sh_mepc : trap_target(cause);
    retire_i  = ret;
    mret_i    = mr;
    pc_next_i = pc;
    tick();
    retire_i = 1'b0;
    mret_i   = 1'b0;
    check_val("redirect_o.valid", {31'b0, redirect_o.valid}, {31'b0, exp_trap | mr});
    if (exp_trap || mr) check_val("redirect_o.pc", redirect_o.pc, exp_pc);
    if (exp_trap) enter_trap(pc, cause);
    else if (mr) leave_trap();
    tick();
    check_val("redirect_o.valid", {31'b0, redirect_o.valid}, 32'h0);  // single pulse
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  initial begin
    logic [31:0] r;
    csr_addr_t   addr;
    seed      = 98465;
    rstn_i    = 1'b0;
    csr_req_i = '0;
    retire_i  = 1'b0;
    mret_i    = 1'b0;
    pc_next_i = '0;
    drive_lines(3'b000);
    reset_shadow();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #10;
    rstn_i = 1'b1;
    check_val("redirect_o.valid", {31'b0, redirect_o.valid}, 32'h0);
    check_val("illegal_o", {31'b0, illegal_o}, 32'h0);
    check_val("rdata_o", rdata_o, 32'h0);

    ////////////////////////////////////////////////////////////////////////////
    // read-only and unknown addresses
    ////////////////////////////////////////////////////////////////////////////
    foreach (RO_ADDRS[i]) begin
      access(RO_ADDRS[i], WRITE, rand_word(), 1'b0);  // illegal, no change
      access(RO_ADDRS[i], CLEAR, rand_word() | 32'h1, 1'b0);
      access(RO_ADDRS[i], SET, 32'h0, 1'b1);  // read back after the writes
    end
    repeat (N_UNK) begin
      do begin
        r    = rand_word();
        addr = r[11:0];
      end while (csr_exists(addr));
      access(addr, rand_op(), rand_word(), 1'b0);
    end

    // random read-modify-write traffic
    repeat (N_RAND) begin
      r = rand_word();
      if (r[3:2] == 2'b00) access(RW_ADDRS[r[31:8] % 6], rand_op(), 32'h0, 1'b1);
      else access(RW_ADDRS[r[31:8] % 6], rand_op(), rand_word(), 1'b0);
    end

    // irq lines into mip, mip writes dropped
    repeat (N_IRQ) begin
      r = rand_word();
      drive_lines(r[2:0]);
      access(CSR_ADDR_MIP, SET, 32'h0, 1'b1);  // new pattern not sampled yet
      if (r[3]) access(CSR_ADDR_MIP, WRITE, rand_word(), 1'b0);
      else access(CSR_ADDR_MIP, SET, rand_word(), 1'b0);
      access(CSR_ADDR_MIP, SET, 32'h0, 1'b1);  // still the lines
    end

    ////////////////////////////////////////////////////////////////////////////
    // trap entry, direct and vectored
    ////////////////////////////////////////////////////////////////////////////
    repeat (N_TRAP) begin
      access(CSR_ADDR_MTVEC, WRITE, rand_word(), 1'b0);
      access(CSR_ADDR_MIE, WRITE, rand_word(), 1'b0);
      r = rand_word();
      if (r[1:0] != 2'b00) r[CSR_BIT_MIE] = 1'b1;  // mostly enabled
      access(CSR_ADDR_MSTATUS, WRITE, r, 1'b0);
      drive_lines(3'(rand_word()));
      tick();
      retire_step(1'b1, 1'b0, rand_word() & 32'hffff_fffc);
      access(CSR_ADDR_MCAUSE, SET, 32'h0, 1'b1);
      access(CSR_ADDR_MEPC, SET, 32'h0, 1'b1);
      access(CSR_ADDR_MSTATUS, SET, 32'h0, 1'b1);
    end

    // trap then mret, sometimes racing a retire with irq pending
    repeat (N_MRET) begin
      access(CSR_ADDR_MIE, WRITE, 32'hffff_ffff, 1'b0);
      access(CSR_ADDR_MSTATUS, WRITE, 32'h1 << CSR_BIT_MIE, 1'b0);
      r = rand_word();
      if (r[2:0] == 3'b000) r[2] = 1'b1;
      drive_lines(r[2:0]);
      tick();
      retire_step(1'b1, 1'b0, rand_word() & 32'hffff_fffc);
      access(CSR_ADDR_MSTATUS, WRITE, rand_word(), 1'b0);  // handler reenables or not
      retire_step(r[4], 1'b1, rand_word() & 32'hffff_fffc);
      access(CSR_ADDR_MSTATUS, SET, 32'h0, 1'b1);
      access(CSR_ADDR_MEPC, SET, 32'h0, 1'b1);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- csr_subsys_top.f
+incdir+verif
src/csr_pkg.sv
src/trap_pkg.sv
src/csr_op_unit.sv
src/csr_regfile.sv
src/trap_ctrl.sv
src/csr_subsys_top.sv
verif/csr_subsys_tb.sv

//--- Makefile
# Verilator flow for the CSR subsystem

VERILATOR  ?= verilator
TB_TOP     ?= csr_subsys_tb
RTL_TOP    ?= csr_subsys_top
FLIST      ?= csr_subsys_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := $(filter src/%.sv,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
